// File: scc_pkg.sv
`default_nettype none

package scc_pkg;

	// ----------------------------------------
	// vector types
	// ----------------------------------------
	typedef logic [15:0] bus_addr_t;
	typedef logic [7:0] bus_data_t;
	// offset inside the 98xxh window
	typedef logic [7:0] reg_ofs_t;
	typedef logic signed [7:0] sample_t;
	typedef logic [4:0] wave_ptr_t;
	typedef logic [1:0] chan_t;
	// channel number in the upper two bits, wave pointer below
	typedef logic [6:0] ram_addr_t;
	typedef logic [11:0] freq_t;
	typedef logic [3:0] vol_t;
	// four products of 8b x 4b, worst case 7680
	typedef logic signed [13:0] mix_t;
	typedef logic [2:0] phase_t;

	// slot bus sequencer
	typedef enum logic [2:0] {
		IDLE,
		WR_COMMIT,
		RD_FETCH,
		RD_DRIVE,
		RELEASE
	} bus_state_t;

	// ----------------------------------------
	// constants
	// ----------------------------------------
	localparam int NUM_CH = 4;
	localparam int SLOT_CLKS = 6;
	localparam bus_data_t BANK_SEL_VAL = 8'h3F;
	localparam reg_ofs_t OFS_FREQ_BASE = 8'h80;
	localparam reg_ofs_t OFS_VOL_BASE = 8'h8A;
	localparam reg_ofs_t OFS_ENABLE = 8'h8F;
	localparam bus_data_t READ_IDLE_VAL = 8'hFF;

endpackage

`default_nettype wire

// File: scc_bus_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module scc_bus_fsm (
	input wire clk,
	input wire w_n_reset,
	input wire n_sltsl,
	input wire n_rd,
	input wire n_wr,
	input wire scc_pkg::bus_addr_t addr,
	input wire scc_pkg::bus_data_t wdata,
	input wire scc_pkg::sample_t bus_rdata,
	output logic reg_wr,
	output scc_pkg::reg_ofs_t reg_ofs,
	output scc_pkg::bus_data_t reg_wdata,
	output logic ram_rd,
	output scc_pkg::bus_data_t rdata,
	output logic rdata_en
);
	import scc_pkg::*;

	bus_state_t state;
	logic ff_n_sltsl;
	logic ff_n_rd;
	logic ff_n_wr;
	bus_addr_t ff_addr;
	bus_data_t ff_wdata;
	logic window_open;
	logic rd_wave;
	logic wr_req;
	logic rd_req;
	logic bank_hit;
	logic win_hit;

	// ----------------------------------------
	// strobe sampling
	// ----------------------------------------
	always_ff @(posedge clk) begin
		ff_addr <= addr;
		ff_wdata <= wdata;
		if (!w_n_reset) begin
			ff_n_sltsl <= 1'b1;
			ff_n_rd <= 1'b1;
			ff_n_wr <= 1'b1;
		end else begin
			ff_n_sltsl <= n_sltsl;
			ff_n_rd <= n_rd;
			ff_n_wr <= n_wr;
		end
	end

	assign wr_req = !ff_n_sltsl && !ff_n_wr;
	assign rd_req = !ff_n_sltsl && !ff_n_rd;
	// bank select register mirrors over 9000h-97FFh
	assign bank_hit = (ff_addr[15:11] == 5'b10010);
	// register window at 98xxh, only while opened
	assign win_hit = window_open && (ff_addr[15:8] == 8'h98);

	// wave bytes come straight from the RAM output, which holds between reads
	assign rdata = rd_wave ? bus_data_t'(bus_rdata) : READ_IDLE_VAL;

	// ----------------------------------------
	// access sequencer
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			state <= IDLE;
			window_open <= 1'b0;
			reg_wr <= 1'b0;
			ram_rd <= 1'b0;
			rdata_en <= 1'b0;
			rd_wave <= 1'b0;
		end else begin
			// single clock pulses by default
			reg_wr <= 1'b0;
			ram_rd <= 1'b0;
			case (state)
				IDLE: begin
					if (wr_req && bank_hit) begin
						// any value but 3Fh closes the window
						window_open <= (ff_wdata == BANK_SEL_VAL);
						state <= RELEASE;
					end else if (wr_req && win_hit) begin
						state <= WR_COMMIT;
					end else if (rd_req && win_hit) begin
						// only 00h-7Fh is backed by wave RAM
						ram_rd <= ~ff_addr[7];
						rd_wave <= ~ff_addr[7];
						state <= RD_FETCH;
					end
				end
				WR_COMMIT: begin
					reg_wr <= 1'b1;
					state <= RELEASE;
				end
				RD_FETCH: begin
					// RAM data lands on this edge
					rdata_en <= 1'b1;
					state <= RD_DRIVE;
				end
				RD_DRIVE: begin
					if (ff_n_rd) begin
						rdata_en <= 1'b0;
						state <= IDLE;
					end
				end
				RELEASE: begin
					// hold off until the host lifts n_wr
					if (ff_n_wr) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// offset and data for the accepted window access
	always_ff @(posedge clk) begin
		if (state == IDLE && (wr_req || rd_req) && win_hit) begin
			reg_ofs <= ff_addr[7:0];
			reg_wdata <= ff_wdata;
		end
	end

	// a write commit never overlaps the read drive phase
	assert property (@(posedge clk) disable iff (!w_n_reset) !(reg_wr && rdata_en));
	assert property (@(posedge clk) disable iff (!w_n_reset)
		state inside {IDLE, WR_COMMIT, RD_FETCH, RD_DRIVE, RELEASE});

endmodule

`default_nettype wire

// File: scc_tone_timer.sv
`timescale 1ns/10ps
`default_nettype none

module scc_tone_timer (
	input wire clk,
	input wire w_n_reset,
	input wire reg_wr,
	input wire scc_pkg::reg_ofs_t reg_ofs,
	input wire scc_pkg::bus_data_t reg_wdata,
	output scc_pkg::phase_t phase,
	output scc_pkg::wave_ptr_t wave_ptr0,
	output scc_pkg::wave_ptr_t wave_ptr1,
	output scc_pkg::wave_ptr_t wave_ptr2,
	output scc_pkg::wave_ptr_t wave_ptr3
);
	import scc_pkg::*;

	freq_t freq [NUM_CH];
	freq_t period_cnt [NUM_CH];
	wave_ptr_t ptr [NUM_CH];
	reg_ofs_t freq_rel;
	logic freq_hit;
	logic slot_tick;

	// 80h-87h, two bytes per channel
	assign freq_rel = reg_ofs - OFS_FREQ_BASE;
	assign freq_hit = reg_wr && (freq_rel < reg_ofs_t'(2 * NUM_CH));
	assign slot_tick = (phase == '0);

	// ----------------------------------------
	// slot phase, 0..5
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			phase <= '0;
		end else if (phase == phase_t'(SLOT_CLKS - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// frequency registers, low byte at even offset, high nibble at odd
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			for (int i = 0; i < NUM_CH; i++) begin
				freq[i] <= '0;
			end
		end else if (freq_hit) begin
			if (freq_rel[0]) begin
				freq[freq_rel[2:1]][11:8] <= reg_wdata[3:0];
			end else begin
				freq[freq_rel[2:1]][7:0] <= reg_wdata;
			end
		end
	end

	// ----------------------------------------
	// period counters
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			for (int i = 0; i < NUM_CH; i++) begin
				period_cnt[i] <= '0;
				ptr[i] <= '0;
			end
		end else if (slot_tick) begin
			for (int i = 0; i < NUM_CH; i++) begin
				if (freq[i] == '0) begin
					// stopped channel keeps its pointer
					period_cnt[i] <= '0;
				end else if (period_cnt[i] == '0) begin
					// f+1 slots per step
					period_cnt[i] <= freq[i];
					ptr[i] <= ptr[i] + 1'b1;
				end else begin
					period_cnt[i] <= period_cnt[i] - 1'b1;
				end
			end
		end
	end

	assign wave_ptr0 = ptr[0];
	assign wave_ptr1 = ptr[1];
	assign wave_ptr2 = ptr[2];
	assign wave_ptr3 = ptr[3];

	assert property (@(posedge clk) disable iff (!w_n_reset) phase < SLOT_CLKS);

endmodule

`default_nettype wire

// File: scc_wave_ram.sv
`timescale 1ns/10ps
`default_nettype none

module scc_wave_ram (
	input wire clk,
	input wire reg_wr,
	input wire scc_pkg::reg_ofs_t reg_ofs,
	input wire scc_pkg::bus_data_t reg_wdata,
	input wire ram_rd,
	input wire scc_pkg::ram_addr_t snd_addr,
	output scc_pkg::sample_t bus_rdata,
	output scc_pkg::sample_t snd_data
);
	import scc_pkg::*;

	// 4 channels x 32 samples
	sample_t mem [2 ** $bits(ram_addr_t)];
	ram_addr_t bus_addr;

	// window offsets 00h-7Fh map one to one
	assign bus_addr = reg_ofs[6:0];

	// ----------------------------------------
	// bus port
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reg_wr && !reg_ofs[7]) begin
			mem[bus_addr] <= sample_t'(reg_wdata);
		end
	end

	// read data holds until the next bus read
	always_ff @(posedge clk) begin
		if (ram_rd) begin
			bus_rdata <= mem[bus_addr];
		end
	end

	// ----------------------------------------
	// sound port
	// ----------------------------------------
	always_ff @(posedge clk) begin
		snd_data <= mem[snd_addr];
	end

endmodule

`default_nettype wire

// File: scc_mixer.sv
`timescale 1ns/10ps
`default_nettype none

module scc_mixer (
	input wire clk,
	input wire w_n_reset,
	input wire reg_wr,
	input wire scc_pkg::reg_ofs_t reg_ofs,
	input wire scc_pkg::bus_data_t reg_wdata,
	input wire scc_pkg::phase_t phase,
	input wire scc_pkg::wave_ptr_t wave_ptr0,
	input wire scc_pkg::wave_ptr_t wave_ptr1,
	input wire scc_pkg::wave_ptr_t wave_ptr2,
	input wire scc_pkg::wave_ptr_t wave_ptr3,
	input wire scc_pkg::sample_t snd_data,
	output scc_pkg::ram_addr_t snd_addr,
	output scc_pkg::mix_t mix_level
);
	import scc_pkg::*;

	vol_t vol [NUM_CH];
	logic [NUM_CH-1:0] ch_en;
	wave_ptr_t ptr [NUM_CH];
	reg_ofs_t vol_rel;
	logic vol_hit;
	chan_t scan_ch;
	chan_t ff_scan_ch;
	logic ff_scan_vld;
	logic signed [12:0] product;
	mix_t acc;

	assign ptr[0] = wave_ptr0;
	assign ptr[1] = wave_ptr1;
	assign ptr[2] = wave_ptr2;
	assign ptr[3] = wave_ptr3;

	// ----------------------------------------
	// volume and enable registers
	// ----------------------------------------
	assign vol_rel = reg_ofs - OFS_VOL_BASE;
	assign vol_hit = reg_wr && (vol_rel < reg_ofs_t'(NUM_CH));

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			for (int i = 0; i < NUM_CH; i++) begin
				vol[i] <= '0;
			end
			ch_en <= '0;
		end else begin
			if (vol_hit) begin
				vol[chan_t'(vol_rel)] <= reg_wdata[3:0];
			end
			if (reg_wr && reg_ofs == OFS_ENABLE) begin
				ch_en <= reg_wdata[NUM_CH-1:0];
			end
		end
	end

	// ----------------------------------------
	// channel scan
	// ----------------------------------------
	// phase 0..3 addresses channel 0..3 and data returns one clock later
	assign scan_ch = chan_t'(phase);
	assign snd_addr = {scan_ch, ptr[scan_ch]};
	// unsigned volume is zero extended before the signed multiply
	assign product = snd_data * $signed({1'b0, vol[ff_scan_ch]});

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_scan_vld <= 1'b0;
			ff_scan_ch <= '0;
			acc <= '0;
			mix_level <= '0;
		end else begin
			ff_scan_vld <= (phase < NUM_CH);
			ff_scan_ch <= scan_ch;
			if (phase == '0) begin
				acc <= '0;
			end else if (ff_scan_vld && ch_en[ff_scan_ch]) begin
				acc <= acc + {product[12], product};
			end
			// last product went in on the phase 4 edge
			if (phase == phase_t'(SLOT_CLKS - 1)) begin
				mix_level <= acc;
			end
		end
	end

	// scanned products land only in phases 1 to 4 between the clear and the latch
	assert property (@(posedge clk) disable iff (!w_n_reset)
		ff_scan_vld |-> (phase != '0) && (phase <= phase_t'(NUM_CH)));

endmodule

`default_nettype wire

// File: scc_pwm_dac.sv
`timescale 1ns/10ps
`default_nettype none

module scc_pwm_dac (
	input wire clk,
	input wire w_n_reset,
	input wire scc_pkg::mix_t mix_level,
	output logic sound_pwm
);
	import scc_pkg::*;

	bus_data_t duty;
	bus_data_t pwm_cnt;

	// offset binary, top 8 bits; zero level gives 128
	assign duty = {~mix_level[13], mix_level[12:6]};

	// ----------------------------------------
	// 256 clock period
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			pwm_cnt <= '0;
			sound_pwm <= 1'b0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
			// high for duty clocks out of every 256
			sound_pwm <= (pwm_cnt < duty);
		end
	end

endmodule

`default_nettype wire

// File: scc_cart_top.sv
`timescale 1ns/10ps
`default_nettype none

module scc_cart_top (
	input wire clk,
	input wire w_n_reset,
	input wire n_sltsl,
	input wire n_rd,
	input wire n_wr,
	input wire scc_pkg::bus_addr_t addr,
	input wire scc_pkg::bus_data_t wdata,
	output scc_pkg::bus_data_t rdata,
	output logic rdata_en,
	output scc_pkg::mix_t mix_level,
	output logic sound_pwm
);
	import scc_pkg::*;

	// register write port, shared by all blocks
	logic reg_wr;
	reg_ofs_t reg_ofs;
	bus_data_t reg_wdata;
	// bus side wave read
	logic ram_rd;
	sample_t bus_rdata;
	// sound side wave read
	ram_addr_t snd_addr;
	sample_t snd_data;
	phase_t phase;
	wave_ptr_t wave_ptr0;
	wave_ptr_t wave_ptr1;
	wave_ptr_t wave_ptr2;
	wave_ptr_t wave_ptr3;

	scc_bus_fsm u_bus_fsm (
		.clk(clk),
		.w_n_reset(w_n_reset),
		.n_sltsl(n_sltsl),
		.n_rd(n_rd),
		.n_wr(n_wr),
		.addr(addr),
		.wdata(wdata),
		.bus_rdata(bus_rdata),
		.reg_wr(reg_wr),
		.reg_ofs(reg_ofs),
		.reg_wdata(reg_wdata),
		.ram_rd(ram_rd),
		.rdata(rdata),
		.rdata_en(rdata_en)
	);

	scc_tone_timer u_tone_timer (
		.clk(clk),
		.w_n_reset(w_n_reset),
		.reg_wr(reg_wr),
		.reg_ofs(reg_ofs),
		.reg_wdata(reg_wdata),
		.phase(phase),
		.wave_ptr0(wave_ptr0),
		.wave_ptr1(wave_ptr1),
		.wave_ptr2(wave_ptr2),
		.wave_ptr3(wave_ptr3)
	);

	scc_wave_ram u_wave_ram (
		.clk(clk),
		.reg_wr(reg_wr),
		.reg_ofs(reg_ofs),
		.reg_wdata(reg_wdata),
		.ram_rd(ram_rd),
		.snd_addr(snd_addr),
		.bus_rdata(bus_rdata),
		.snd_data(snd_data)
	);

	scc_mixer u_mixer (
		.clk(clk),
		.w_n_reset(w_n_reset),
		.reg_wr(reg_wr),
		.reg_ofs(reg_ofs),
		.reg_wdata(reg_wdata),
		.phase(phase),
		.wave_ptr0(wave_ptr0),
		.wave_ptr1(wave_ptr1),
		.wave_ptr2(wave_ptr2),
		.wave_ptr3(wave_ptr3),
		.snd_data(snd_data),
		.snd_addr(snd_addr),
		.mix_level(mix_level)
	);

	scc_pwm_dac u_pwm_dac (
		.clk(clk),
		.w_n_reset(w_n_reset),
		.mix_level(mix_level),
		.sound_pwm(sound_pwm)
	);

endmodule

`default_nettype wire

// File: tb_scc_cart.sv
`timescale 1ns/10ps
`default_nettype none

module tb_scc_cart;
	import scc_pkg::*;

	localparam int CLK_HALF = 20;
	localparam int RESET_CYCLES = 16;
	// well above the combined length of the directed tests
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int STRB_CYCLES = 6;

	logic clk;
	logic w_n_reset;
	logic n_sltsl;
	logic n_rd;
	logic n_wr;
	bus_addr_t addr;
	bus_data_t wdata;
	bus_data_t rdata;
	logic rdata_en;
	mix_t mix_level;
	logic sound_pwm;

	integer seed;
	int cycle_cnt = 0;
	// expected contents of wave RAM and mixer registers
	int model_wave [128];
	int model_vol [NUM_CH];
	logic [NUM_CH-1:0] model_en;

	scc_cart_top u_scc_cart_top (
		.clk(clk),
		.w_n_reset(w_n_reset),
		.n_sltsl(n_sltsl),
		.n_rd(n_rd),
		.n_wr(n_wr),
		.addr(addr),
		.wdata(wdata),
		.rdata(rdata),
		.rdata_en(rdata_en),
		.mix_level(mix_level),
		.sound_pwm(sound_pwm)
	);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// ----------------------------------------
	// failure reporting and run limit
	// ----------------------------------------
	task automatic report_failure(input string text);
		$display("%s", text);
		$display("TESTS FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_equal(input string name, input int expected, input int actual);
		assert (actual == expected) else report_failure($sformatf(
			"[ERROR] t=%0t %s expected %0d actual %0d", $time, name, expected, actual));
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			report_failure("timeout, the tests did not finish within the cycle limit");
		end
	end

	// ----------------------------------------
	// slot bus accesses
	// ----------------------------------------
	task automatic bus_write(input bus_addr_t wr_addr, input bus_data_t wr_data);
		@(posedge clk);
		addr <= wr_addr;
		wdata <= wr_data;
		n_sltsl <= 1'b0;
		n_wr <= 1'b0;
		repeat (STRB_CYCLES) @(posedge clk);
		n_sltsl <= 1'b1;
		n_wr <= 1'b1;
		// fsm leaves RELEASE once n_wr is seen high
		repeat (3) @(posedge clk);
	endtask

	task automatic bus_read(input bus_addr_t rd_addr, output bus_data_t rd_data,
			output logic got);
		int wait_cnt;
		got = 1'b0;
		rd_data = '0;
		wait_cnt = 0;
		@(posedge clk);
		addr <= rd_addr;
		n_sltsl <= 1'b0;
		n_rd <= 1'b0;
		repeat (STRB_CYCLES) begin
			@(negedge clk);
			if (rdata_en) begin
				got = 1'b1;
				rd_data = rdata;
			end
			@(posedge clk);
		end
		n_sltsl <= 1'b1;
		n_rd <= 1'b1;
		// drive ends one clock after n_rd is sampled high
		@(negedge clk);
		while (rdata_en && wait_cnt < 8) begin
			@(negedge clk);
			wait_cnt++;
		end
		assert (!rdata_en) else report_failure("rdata_en stayed high after n_rd was released");
		repeat (2) @(posedge clk);
	endtask

	task automatic write_wave(input int ch, input int idx, input int value);
		bus_write(bus_addr_t'(16'h9800 + ch * 32 + idx), bus_data_t'(value));
		model_wave[ch * 32 + idx] = value;
	endtask

	// all pointers rest at 0 while every frequency is 0
	function automatic int steady_mix_value();
		int sum;
		sum = 0;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			if (model_en[ch]) begin
				sum += model_wave[ch * 32] * model_vol[ch];
			end
		end
		return sum;
	endfunction

	task automatic count_pwm_high(output int high_cnt);
		high_cnt = 0;
		repeat (256) begin
			@(negedge clk);
			if (sound_pwm) begin
				high_cnt++;
			end
		end
	endtask

	task automatic wait_mix_change(output int gap);
		mix_t start;
		start = mix_level;
		gap = 0;
		do begin
			@(negedge clk);
			gap++;
		end while (mix_level == start && gap < 100);
		assert (mix_level != start) else report_failure("mix_level did not change while stepping");
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic test_reset_state();
		int high_cnt;
		@(negedge clk);
		check_equal("rdata_en", 0, rdata_en);
		check_equal("mix_level", 0, mix_level);
		// zero level sits at midscale
		count_pwm_high(high_cnt);
		check_equal("sound_pwm high count", 128, high_cnt);
	endtask

	task automatic test_window_gating();
		bus_data_t data;
		logic got;
		bus_data_t written [32];
		bus_read(16'h9805, data, got);
		check_equal("rdata_en on closed window", 0, got);
		bus_write(16'h9000, 8'h3F);
		// channel 2 lives at 40h-5Fh
		for (int k = 0; k < 32; k++) begin
			written[k] = bus_data_t'($random(seed));
			write_wave(2, k, $signed(written[k]));
		end
		for (int k = 0; k < 32; k++) begin
			bus_read(bus_addr_t'(16'h9840 + k), data, got);
			check_equal("rdata_en", 1, got);
			check_equal("rdata", written[k], data);
		end
		bus_write(16'h9000, 8'h00);
		bus_read(16'h9840, data, got);
		check_equal("rdata_en after close", 0, got);
	endtask

	task automatic test_register_reads();
		bus_addr_t ofs_list [3] = '{16'h9880, 16'h988F, 16'h98F3};
		bus_data_t data;
		logic got;
		bus_write(16'h9000, 8'h3F);
		foreach (ofs_list[i]) begin
			bus_read(ofs_list[i], data, got);
			check_equal("rdata_en", 1, got);
			check_equal("rdata", 8'hFF, data);
		end
	endtask

	task automatic settle_and_check_mix();
		repeat (20) @(negedge clk);
		check_equal("mix_level", steady_mix_value(), mix_level);
	endtask

	task automatic test_steady_mix();
		for (int k = 0; k < 32; k++) begin
			write_wave(0, k, 20);
		end
		bus_write(16'h988A, 8'd15);
		model_vol[0] = 15;
		bus_write(16'h988F, 8'h01);
		model_en = 4'b0001;
		settle_and_check_mix();
		// second channel pulls the sum down
		for (int k = 0; k < 32; k++) begin
			write_wave(1, k, -10);
		end
		bus_write(16'h988B, 8'd8);
		model_vol[1] = 8;
		bus_write(16'h988F, 8'h03);
		model_en = 4'b0011;
		settle_and_check_mix();
		bus_write(16'h988F, 8'h02);
		model_en = 4'b0010;
		settle_and_check_mix();
	endtask

	task automatic test_pwm_duty();
		int high_cnt;
		int expected;
		bus_write(16'h988F, 8'h01);
		model_en = 4'b0001;
		settle_and_check_mix();
		// offset binary adds half the 14 bit range and the duty is its top byte
		expected = (steady_mix_value() + 8192) >> 6;
		count_pwm_high(high_cnt);
		check_equal("sound_pwm high count", expected, high_cnt);
	endtask

	task automatic test_wave_stepping();
		int gap;
		int ptr;
		int expected;
		for (int k = 0; k < 32; k++) begin
			write_wave(0, k, k - 16);
		end
		// frequency 3, so one step per 4 slots
		bus_write(16'h9880, 8'd3);
		@(negedge clk);
		// pointer leaves sample 0 on the first slot after the write
		ptr = 1;
		wait_mix_change(gap);
		check_equal("mix_level step", model_wave[ptr] * model_vol[0], mix_level);
		repeat (40) begin
			ptr = (ptr + 1) % 32;
			wait_mix_change(gap);
			check_equal("mix_level step", model_wave[ptr] * model_vol[0], mix_level);
			check_equal("step spacing in cycles", 6 * (3 + 1), gap);
		end
		// frequency 0 stops the pointer before its next step
		bus_write(16'h9880, 8'd0);
		repeat (14) @(negedge clk);
		expected = model_wave[ptr] * model_vol[0];
		repeat (200) begin
			@(negedge clk);
			check_equal("mix_level hold", expected, mix_level);
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		seed = 32'hf108;
		w_n_reset = 1'b0;
		n_sltsl = 1'b1;
		n_rd = 1'b1;
		n_wr = 1'b1;
		addr = '0;
		wdata = '0;
		model_en = '0;
		foreach (model_wave[i]) begin
			model_wave[i] = 0;
		end
		foreach (model_vol[i]) begin
			model_vol[i] = 0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		w_n_reset <= 1'b1;
		test_reset_state();
		test_window_gating();
		test_register_reads();
		test_steady_mix();
		test_pwm_duty();
		test_wave_stepping();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
scc_pkg.sv
scc_bus_fsm.sv
scc_tone_timer.sv
scc_wave_ram.sv
scc_mixer.sv
scc_pwm_dac.sv
scc_cart_top.sv
tb_scc_cart.sv

// File: Bender.yml
package:
  name: scc_cart

sources:
  - scc_pkg.sv
  - scc_bus_fsm.sv
  - scc_tone_timer.sv
  - scc_wave_ram.sv
  - scc_mixer.sv
  - scc_pwm_dac.sv
  - scc_cart_top.sv
  - target: test
    files:
      - tb_scc_cart.sv
